//--- list.f
src/uart_pkg.sv
src/byte_ring.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_access.sv
src/uart_top.sv
tests/clock_gen.sv
tests/uart_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 -f list.f --top-module uart_tb \
    -o uart_sim \
    && ./obj_dir/uart_sim \
    || exit 1

//--- tests/uart_cases.txt
# columns: op (W write, R read and compare, B burst), offset, hex value, name
# a B line writes value random bytes to the offset and reads them back in order
R C 00001000 reset_status
W 0 ffffff5a byte_write
R 0 0000005a byte_read
W 8 04030201 word_write
R 0 00000001 word_lane0
R 0 00000002 word_lane1
R 0 00000003 word_lane2
R 0 00000004 word_lane3
W 4 a5a5beef half_write
R 4 0000beef half_read
W 0 00000011 drain_byte0
W 0 00000022 drain_byte1
W 4 00004433 drain_half
R C 00001004 drain_status
R 8 44332211 drain_word
W 0 0000007e err_setup
R C 00001001 err_before
W 2 deadbeef err_write
R 6 00000000 err_read
R C 00001001 err_after
R 0 0000007e err_cleanup
B 0 00000014 overflow_burst
R C 00001000 final_status

//--- tests/uart_tb.sv
module uart_tb import uart_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam realtime CLK_PERIOD = 40.0;
    localparam realtime FRAME_TIME = 10 * CLKS_PER_BIT * CLK_PERIOD;

    logic  clk;
    logic  rstn;
    logic  awvalid;
    logic  awready;
    addr_t awaddr;
    logic  wvalid;
    logic  wready;
    word_t wdata;
    logic  bvalid;
    logic  bready;
    resp_t bresp;
    logic  arvalid;
    logic  arready;
    addr_t araddr;
    logic  rvalid;
    logic  rready;
    word_t rdata;
    resp_t rresp;
    logic  serial_line; // o_tx looped straight back into i_rx

    string       case_op[$];
    addr_t       case_addr[$];
    word_t       case_value[$];
    string       case_name[$];
    logic        cases_loaded;
    int          work_units;
    logic [31:0] lfsr_state;

    clock_gen u_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    uart_top dut (
        .i_awvalid (awvalid),
        .o_awready (awready),
        .i_awaddr  (awaddr),
        .i_wvalid  (wvalid),
        .o_wready  (wready),
        .i_wdata   (wdata),
        .o_bvalid  (bvalid),
        .i_bready  (bready),
        .o_bresp   (bresp),
        .i_arvalid (arvalid),
        .o_arready (arready),
        .i_araddr  (araddr),
        .o_rvalid  (rvalid),
        .i_rready  (rready),
        .o_rdata   (rdata),
        .o_rresp   (rresp),
        .i_rx      (serial_line),
        .o_tx      (serial_line),
        .clk       (clk),
        .rstn      (rstn)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                name, expected, actual));
        end
    endtask

    // right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic next_lfsr_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out_bit;
    endfunction

    function automatic byte_t random_byte();
        byte_t value;
        for (int i = 0; i < 8; i++) begin
            value[i] = next_lfsr_bit();
        end
        return value;
    endfunction

    // only the three data registers and a status read are in the map
    function automatic resp_t expected_resp(input string op, input addr_t addr);
        if (addr == REG_DATA_B || addr == REG_DATA_H || addr == REG_DATA_W) begin
            return RESP_OKAY;
        end
        if (addr == REG_STATUS && op == "R") begin
            return RESP_OKAY;
        end
        return RESP_SLVERR;
    endfunction

    task automatic load_cases();
        int    fd;
        int    fields;
        string line;
        string op;
        addr_t addr;
        word_t value;
        string name;
        fd = $fopen("tests/uart_cases.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open the case file tests/uart_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %s", op, addr, value, name);
            if (fields != 4) begin
                stop_with_failure({"the case file has a malformed line: ", line});
            end
            case_op.push_back(op);
            case_addr.push_back(addr);
            case_value.push_back(value);
            case_name.push_back(name);
            work_units += (op == "B") ? int'(value) : 1; // a burst costs one unit per byte
        end
        $fclose(fd);
    endtask

    task automatic axi_write(input addr_t addr, input word_t data, output resp_t resp,
                             output int latency);
        @(negedge clk);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        bready  = 1'b1;
        do begin
            @(posedge clk);
        end while (!(awready && wready));
        latency = 0;
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do begin
            @(posedge clk);
            latency++;
        end while (!bvalid);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, output word_t data, output resp_t resp,
                            output int latency);
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b1;
        do begin
            @(posedge clk);
        end while (!arready);
        latency = 0;
        @(negedge clk);
        arvalid = 1'b0;
        do begin
            @(posedge clk);
            latency++;
        end while (!rvalid);
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // a frame holds at most nine high bits in a row, so eleven quiet bit
    // times mean the tx ring is empty and the receiver has pushed its last byte
    task automatic wait_line_idle();
        int quiet;
        quiet = 0;
        while (quiet < 11 * CLKS_PER_BIT) begin
            @(negedge clk);
            quiet = serial_line ? quiet + 1 : 0;
        end
    endtask

    task automatic run_burst(input string name, input addr_t addr, input int n_bytes);
        byte_t sent[$];
        byte_t value;
        word_t data;
        resp_t resp;
        int    latency;
        for (int i = 0; i < n_bytes; i++) begin
            value = random_byte();
            sent.push_back(value);
            axi_write(addr, {24'd0, value}, resp, latency);
            compare_word($sformatf("%s write %0d bresp", name, i), RESP_OKAY, resp);
        end
        for (int i = 0; i < n_bytes; i++) begin
            axi_read(addr, data, resp, latency);
            compare_word($sformatf("%s byte %0d", name, i), {24'd0, sent[i]}, data);
            compare_word($sformatf("%s read %0d rresp", name, i), RESP_OKAY, resp);
        end
    endtask

    task automatic run_case(input int idx);
        string name;
        addr_t addr;
        word_t value;
        word_t data;
        resp_t resp;
        int    latency;
        logic  timed;
        name  = case_name[idx];
        addr  = case_addr[idx];
        value = case_value[idx];
        timed = 1'b0;
        if (case_op[idx] == "W") begin
            axi_write(addr, value, resp, latency);
            compare_word({name, " bresp"}, expected_resp("W", addr), resp);
            timed = 1'b1;
        end else if (case_op[idx] == "R") begin
            if (addr == REG_STATUS) begin
                wait_line_idle();
            end
            axi_read(addr, data, resp, latency);
            compare_word(name, value, data);
            compare_word({name, " rresp"}, expected_resp("R", addr), resp);
            timed = 1'b1;
        end else if (case_op[idx] == "B") begin
            run_burst(name, addr, int'(value));
        end else begin
            stop_with_failure({"the case file names an unknown operation in ", name});
        end
        // status and unmapped accesses answer a fixed two cycles after the handshake
        if (timed && (addr == REG_STATUS || expected_resp("R", addr) == RESP_SLVERR)) begin
            compare_word({name, " latency"}, 32'd2, word_t'(latency));
        end
    endtask

    initial begin
        wait (cases_loaded === 1'b1);
        #(work_units * 12 * FRAME_TIME);
        stop_with_failure("the watchdog expired before all cases had finished");
    end

    initial begin
        int idx;
        awvalid      = 1'b0;
        awaddr       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        bready       = 1'b0;
        arvalid      = 1'b0;
        araddr       = '0;
        rready       = 1'b0;
        lfsr_state   = 32'h3368_6f0e;
        cases_loaded = 1'b0;
        work_units   = 0;
        load_cases();
        cases_loaded = 1'b1;
        wait (rstn === 1'b1);
        repeat (4 * CLKS_PER_BIT) begin
            @(negedge clk);
            compare_word("reset_line_idle", 32'd1, {31'd0, serial_line});
        end
        for (idx = 0; idx < case_op.size(); idx++) begin
            run_case(idx);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- tests/clock_gen.sv
module clock_gen (
    output logic clk,
    output logic rstn
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

//--- src/uart_top.sv
module uart_top import uart_pkg::*; (
    input  logic  i_awvalid,
    output logic  o_awready,
    input  addr_t i_awaddr,
    input  logic  i_wvalid,
    output logic  o_wready,
    input  word_t i_wdata,
    output logic  o_bvalid,
    input  logic  i_bready,
    output resp_t o_bresp,
    input  logic  i_arvalid,
    output logic  o_arready,
    input  addr_t i_araddr,
    output logic  o_rvalid,
    input  logic  i_rready,
    output word_t o_rdata,
    output resp_t o_rresp,
    input  logic  i_rx,
    output logic  o_tx,
    input  logic  clk,
    input  logic  rstn
);

    logic      tx_push;
    byte_t     tx_push_data;
    logic      tx_pop;
    byte_t     tx_pop_data;
    logic      tx_pop_done;
    ring_cnt_t tx_count;

    logic      rx_push;
    byte_t     rx_push_data;
    logic      rx_pop;
    byte_t     rx_pop_data;
    logic      rx_pop_done;
    ring_cnt_t rx_count;

    uart_access u_access (
        .i_awvalid  (i_awvalid),
        .o_awready  (o_awready),
        .i_awaddr   (i_awaddr),
        .i_wvalid   (i_wvalid),
        .o_wready   (o_wready),
        .i_wdata    (i_wdata),
        .o_bvalid   (o_bvalid),
        .i_bready   (i_bready),
        .o_bresp    (o_bresp),
        .i_arvalid  (i_arvalid),
        .o_arready  (o_arready),
        .i_araddr   (i_araddr),
        .o_rvalid   (o_rvalid),
        .i_rready   (i_rready),
        .o_rdata    (o_rdata),
        .o_rresp    (o_rresp),
        .o_tx_push  (tx_push),
        .o_tx_data  (tx_push_data),
        .i_tx_count (tx_count),
        .o_rx_pop   (rx_pop),
        .i_rx_data  (rx_pop_data),
        .i_rx_done  (rx_pop_done),
        .i_rx_count (rx_count),
        .clk        (clk),
        .rstn       (rstn)
    );

    byte_ring tx_ring (
        .i_push      (tx_push),
        .i_push_data (tx_push_data),
        .i_pop       (tx_pop),
        .o_pop_data  (tx_pop_data),
        .o_pop_done  (tx_pop_done),
        .o_count     (tx_count),
        .clk         (clk),
        .rstn        (rstn)
    );

    byte_ring rx_ring (
        .i_push      (rx_push),
        .i_push_data (rx_push_data),
        .i_pop       (rx_pop),
        .o_pop_data  (rx_pop_data),
        .o_pop_done  (rx_pop_done),
        .o_count     (rx_count),
        .clk         (clk),
        .rstn        (rstn)
    );

    uart_tx u_tx (
        .i_ring_count (tx_count),
        .o_pop        (tx_pop),
        .i_data       (tx_pop_data),
        .i_data_valid (tx_pop_done),
        .o_tx         (o_tx),
        .clk          (clk),
        .rstn         (rstn)
    );

    uart_rx u_rx (
        .i_rx    (i_rx),
        .o_valid (rx_push),
        .o_data  (rx_push_data),
        .clk     (clk),
        .rstn    (rstn)
    );

endmodule

//--- src/uart_access.sv
module uart_access import uart_pkg::*; (
    input  logic      i_awvalid,
    output logic      o_awready,
    input  addr_t     i_awaddr,
    input  logic      i_wvalid,
    output logic      o_wready,
    input  word_t     i_wdata,
    output logic      o_bvalid,
    input  logic      i_bready,
    output resp_t     o_bresp,
    input  logic      i_arvalid,
    output logic      o_arready,
    input  addr_t     i_araddr,
    output logic      o_rvalid,
    input  logic      i_rready,
    output word_t     o_rdata,
    output resp_t     o_rresp,
    output logic      o_tx_push,
    output byte_t     o_tx_data,
    input  ring_cnt_t i_tx_count,
    output logic      o_rx_pop,
    input  byte_t     i_rx_data,
    input  logic      i_rx_done,
    input  ring_cnt_t i_rx_count,
    input  logic      clk,
    input  logic      rstn
);

    typedef enum logic [2:0] {
        ACC_IDLE, ACC_WRITE, ACC_READ, ACC_WAIT, ACC_BRESP, ACC_RRESP
    } acc_state_t;

    acc_state_t state;
    word_t      wr_word;
    logic [2:0] cnt_req;   // bytes still to push, or still to request from the rx ring
    logic [1:0] rx_lane;
    logic [1:0] last_lane;
    logic       wait_rd;
    logic       wr_req;
    logic [2:0] aw_len;
    logic [2:0] ar_len;
    ring_cnt_t  tx_free;
    word_t      status_word;

    // 0 means status or an unmapped offset
    function automatic logic [2:0] data_len(input addr_t addr);
        case (addr)
            REG_DATA_B: data_len = 3'd1;
            REG_DATA_H: data_len = 3'd2;
            REG_DATA_W: data_len = 3'd4;
            default:    data_len = 3'd0;
        endcase
    endfunction

    assign aw_len      = data_len(i_awaddr);
    assign ar_len      = data_len(i_araddr);
    assign tx_free     = RING_FULL - i_tx_count;
    assign status_word = {19'd0, tx_free, 3'd0, i_rx_count};

    assign wr_req    = i_awvalid && i_wvalid;
    assign o_awready = (state == ACC_IDLE) && wr_req;
    assign o_wready  = o_awready;
    assign o_arready = (state == ACC_IDLE) && !wr_req; // writes win a tie
    assign o_bvalid  = (state == ACC_BRESP);
    assign o_rvalid  = (state == ACC_RRESP);

    assign o_tx_data = wr_word[7:0];
    assign o_tx_push = (state == ACC_WRITE) && (i_tx_count != RING_FULL);
    assign o_rx_pop  = (state == ACC_READ) && (cnt_req != '0) && (i_rx_count != '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ACC_IDLE;
        end else begin
            case (state)
                ACC_IDLE: begin
                    if (wr_req) begin
                        wait_rd <= 1'b0;
                        if (aw_len != '0) begin
                            wr_word <= i_wdata;
                            cnt_req <= aw_len;
                            o_bresp <= RESP_OKAY;
                            state   <= ACC_WRITE;
                        end else begin
                            o_bresp <= RESP_SLVERR; // status is read only
                            state   <= ACC_WAIT;
                        end
                    end else if (i_arvalid) begin
                        wait_rd <= 1'b1;
                        o_rdata <= (i_araddr == REG_STATUS) ? status_word : '0;
                        if (ar_len != '0) begin
                            cnt_req   <= ar_len;
                            rx_lane   <= '0;
                            last_lane <= 2'(ar_len - 3'd1);
                            o_rresp   <= RESP_OKAY;
                            state     <= ACC_READ;
                        end else begin
                            o_rresp <= (i_araddr == REG_STATUS) ? RESP_OKAY : RESP_SLVERR;
                            state   <= ACC_WAIT;
                        end
                    end
                end
                ACC_WRITE: begin
                    if (o_tx_push) begin
                        wr_word <= wr_word >> 8;
                        cnt_req <= cnt_req - 3'd1;
                        if (cnt_req == 3'd1) begin
                            state <= ACC_BRESP;
                        end
                    end
                end
                ACC_READ: begin
                    if (o_rx_pop) begin
                        cnt_req <= cnt_req - 3'd1;
                    end
                    if (i_rx_done) begin
                        o_rdata[8*rx_lane +: 8] <= i_rx_data;
                        rx_lane <= rx_lane + 2'd1;
                        if (rx_lane == last_lane) begin
                            state <= ACC_RRESP;
                        end
                    end
                end
                ACC_WAIT: begin
                    state <= wait_rd ? ACC_RRESP : ACC_BRESP;
                end
                ACC_BRESP: begin
                    if (i_bready) begin
                        state <= ACC_IDLE;
                    end
                end
                default: begin
                    if (i_rready) begin
                        state <= ACC_IDLE;
                    end
                end
            endcase
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rstn)
        o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp));

endmodule

//--- src/uart_tx.sv
module uart_tx import uart_pkg::*; (
    input  ring_cnt_t i_ring_count,
    output logic      o_pop,
    input  byte_t     i_data,
    input  logic      i_data_valid,
    output logic      o_tx,
    input  logic      clk,
    input  logic      rstn
);

    typedef enum logic [2:0] {TX_IDLE, TX_FETCH, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t  state;
    byte_t      shift;
    bit_cnt_t   tick;
    logic [2:0] bit_idx;
    logic       bit_end;

    assign o_pop   = (state == TX_IDLE) && (i_ring_count != '0);
    assign bit_end = (tick == BIT_LAST);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tick <= '0;
        end else if (state == TX_START || state == TX_DATA || state == TX_STOP) begin
            tick <= bit_end ? '0 : tick + 1'b1;
        end else begin
            tick <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= TX_IDLE;
            bit_idx <= '0;
            o_tx    <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (o_pop) begin
                        state <= TX_FETCH;
                    end
                end
                TX_FETCH: begin
                    if (i_data_valid) begin // ring answers one cycle after the pop
                        shift <= i_data;
                        o_tx  <= 1'b0;
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        o_tx    <= shift[0];
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        shift   <= shift >> 1;
                        if (bit_idx == 3'd7) begin
                            o_tx  <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            o_tx <= shift[1];
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= TX_IDLE;
                    end
                end
            endcase
        end
    end

    // the line only goes low inside a frame, and no byte is fetched then
    a_no_pop_in_frame: assert property (@(posedge clk) disable iff (!rstn)
        !o_tx |-> !o_pop);

endmodule

//--- src/uart_rx.sv
module uart_rx import uart_pkg::*; (
    input  logic  i_rx,
    output logic  o_valid,
    output byte_t o_data,
    input  logic  clk,
    input  logic  rstn
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t  state;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    bit_cnt_t   tick;
    logic [2:0] bit_idx;
    byte_t      shift;
    logic       bit_end;

    assign bit_end = (tick == BIT_LAST);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rx_meta <= 1'b1; // line idles high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= RX_IDLE;
            tick    <= '0;
            bit_idx <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (tick == HALF_LAST) begin
                        tick    <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA; // glitch, not a start bit
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        tick    <= '0;
                        shift   <= {rx_sync, shift[7:1]}; // lsb arrives first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        tick  <= '0;
                        state <= RX_IDLE;
                        if (rx_sync) begin
                            o_valid <= 1'b1;
                            o_data  <= shift;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- src/byte_ring.sv
module byte_ring import uart_pkg::*; (
    input  logic      i_push,
    input  byte_t     i_push_data,
    input  logic      i_pop,
    output byte_t     o_pop_data,
    output logic      o_pop_done,
    output ring_cnt_t o_count,
    input  logic      clk,
    input  logic      rstn
);

    byte_t     mem [RING_DEPTH];
    ring_idx_t wr_idx; // next slot to write
    ring_idx_t rd_idx; // next slot to read
    logic      do_push;
    logic      do_pop;

    assign do_pop  = i_pop && (o_count != '0);
    // a full ring still accepts a push when a pop frees a slot on the same edge
    assign do_push = i_push && ((o_count != RING_FULL) || do_pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_idx] <= i_push_data;
        end
        if (do_pop) begin
            o_pop_data <= mem[rd_idx]; // old contents even if wr_idx == rd_idx
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_idx     <= '0;
            rd_idx     <= '0;
            o_count    <= '0;
            o_pop_done <= 1'b0;
        end else begin
            o_pop_done <= do_pop;
            if (do_push) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (do_pop) begin
                rd_idx <= rd_idx + 1'b1;
            end
            if (do_push && !do_pop) begin
                o_count <= o_count + 1'b1;
            end else if (do_pop && !do_push) begin
                o_count <= o_count - 1'b1;
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rstn)
        o_count <= RING_FULL);

endmodule

//--- src/uart_pkg.sv
package uart_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  addr_t;
    typedef logic [4:0]  ring_cnt_t;
    typedef logic [1:0]  resp_t;

    localparam int RING_DEPTH   = 16;
    localparam int CLKS_PER_BIT = 8;

    // index and bit-timer widths follow the two constants above
    localparam int RING_IDX_W = $clog2(RING_DEPTH);
    localparam int BIT_CNT_W  = $clog2(CLKS_PER_BIT);

    typedef logic [RING_IDX_W-1:0] ring_idx_t;
    typedef logic [BIT_CNT_W-1:0]  bit_cnt_t;

    localparam ring_cnt_t RING_FULL = ring_cnt_t'(RING_DEPTH);
    localparam bit_cnt_t  BIT_LAST  = bit_cnt_t'(CLKS_PER_BIT - 1);
    localparam bit_cnt_t  HALF_LAST = bit_cnt_t'(CLKS_PER_BIT / 2 - 1);

    localparam addr_t REG_DATA_B = 4'h0;
    localparam addr_t REG_DATA_H = 4'h4;
    localparam addr_t REG_DATA_W = 4'h8;
    localparam addr_t REG_STATUS = 4'hC;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage
